// File: all.f
common/tag_pkg.sv
tag_bank/bram_subbank.sv
tag_bank/tag_bank.sv
src/tag_compare.sv
src/tag_store_top.sv
test/tag_store_props.sv
test/tag_store_tb.sv

// File: Makefile
# Verilator build of the cache tag store testbench
# The simulation exits with a non-zero status when the testbench fails

VERILATOR ?= verilator
TOP       := tag_store_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
VFLAGS    += --top-module $(TOP) -Mdir $(BUILD_DIR)

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: test/tag_store_tb.sv
//--------------------------------------------------------------------------
// Testbench for the cache tag store
// Directed table first, then random fills and lookups from a 16-bit LFSR
// Inputs change on the falling edge, outputs are checked there as well
// Expected responses come from a 128-entry model updated by each fill
// The first mismatch ends the run through $fatal
//--------------------------------------------------------------------------
module tag_store_tb
   import tag_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES   = 4;
   localparam int NUM_ROWS       = 24;
   localparam int RAND_OPS       = 200;
   localparam int DRAIN_LIMIT    = 4;
   localparam int TIMEOUT_CYCLES = 2 * (NUM_ROWS + RAND_OPS) + RESET_CYCLES;

   // Op code bit 0 is a lookup, bit 1 a fill
   localparam logic [1:0] OP_IDLE = 2'd0;
   localparam logic [1:0] OP_LK   = 2'd1;
   localparam logic [1:0] OP_FILL = 2'd2;
   localparam logic [1:0] OP_BOTH = 2'd3;

   typedef struct packed {
      logic [1:0] op;
      index_t     index;
      tag_t       tag;
      logic       valid;
   } stim_row_t;

   // DUT ports
   logic        clka;
   logic        rst_n;
   logic        lookup_valid;
   lookup_req_t lookup;
   logic        fill_valid;
   fill_req_t   fill;
   logic        rsp_valid;
   lookup_rsp_t rsp;

   // Reference model and response tracking
   tag_entry_t  model [2**INDEX_W];
   lookup_rsp_t exp_q [$];
   logic        lookup_d1;
   int          cycle_cnt;
   logic [15:0] lfsr_state;

   // Directed rows, one per cycle
   stim_row_t stim_table [NUM_ROWS] = '{
      // Empty entries in all four subbanks
      '{OP_LK,   7'h03, 23'h000000, 1'b0},
      '{OP_LK,   7'h25, 23'h001234, 1'b0},
      '{OP_LK,   7'h4A, 23'h000000, 1'b0},
      '{OP_LK,   7'h7F, 23'h7FFFFF, 1'b0},
      '{OP_IDLE, 7'h00, 23'h000000, 1'b0},
      // Fill then hit, then same index with another tag
      '{OP_FILL, 7'h25, 23'h0ABCDE, 1'b1},
      '{OP_LK,   7'h25, 23'h0ABCDE, 1'b0},
      '{OP_LK,   7'h25, 23'h0ABCDF, 1'b0},
      // Invalidate
      '{OP_FILL, 7'h25, 23'h0ABCDE, 1'b0},
      '{OP_LK,   7'h25, 23'h0ABCDE, 1'b0},
      // Same-cycle fill and lookup of one index
      '{OP_FILL, 7'h4A, 23'h111111, 1'b1},
      '{OP_BOTH, 7'h4A, 23'h222222, 1'b1},
      '{OP_LK,   7'h4A, 23'h222222, 1'b0},
      // One entry per subbank, then read back to back
      '{OP_FILL, 7'h03, 23'h7A5A5A, 1'b1},
      '{OP_FILL, 7'h60, 23'h012345, 1'b1},
      '{OP_FILL, 7'h3C, 23'h654321, 1'b1},
      '{OP_FILL, 7'h5F, 23'h2AAAAA, 1'b1},
      '{OP_LK,   7'h03, 23'h7A5A5A, 1'b0},
      '{OP_LK,   7'h60, 23'h012345, 1'b0},
      '{OP_LK,   7'h3C, 23'h654321, 1'b0},
      '{OP_LK,   7'h5F, 23'h2AAAAA, 1'b0},
      '{OP_LK,   7'h03, 23'h7A5A5A, 1'b0},
      '{OP_LK,   7'h60, 23'h000000, 1'b0},
      '{OP_IDLE, 7'h00, 23'h000000, 1'b0}
   };

   tag_store_top DUT (
      .clka         (clka),
      .rst_n        (rst_n),
      .lookup_valid (lookup_valid),
      .lookup       (lookup),
      .fill_valid   (fill_valid),
      .fill         (fill),
      .rsp_valid    (rsp_valid),
      .rsp          (rsp)
   );

   // 40 ns clock
   always #20 clka = ~clka;

   task automatic stop_run();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   // Run limit
   always @(posedge clka) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
         stop_run();
      end
   end

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL time=%0t %s got=%b expected=%b", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_entry(input string name, input tag_entry_t got,
                              input tag_entry_t exp);
      if (got !== exp) begin
         $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_rsp(input string name, input lookup_rsp_t got,
                            input lookup_rsp_t exp);
      check_bit({name, ".hit"}, got.hit, exp.hit);
      check_entry({name, ".entry"}, got.entry, exp.entry);
   endtask

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, output logic [31:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         bits = {bits[30:0], lfsr_state[0]};
      end
   endtask

   // Response of the lookup driven one falling edge earlier
   task automatic check_outputs();
      lookup_rsp_t exp_rsp;
      check_bit("rsp_valid", rsp_valid, lookup_d1);
      if (rsp_valid) begin
         if (exp_q.size() == 0) begin
            $display("A response arrived with no lookup outstanding at %0t", $time);
            stop_run();
         end else begin
            exp_rsp = exp_q.pop_front();
            check_rsp("rsp", rsp, exp_rsp);
         end
      end
   endtask

   // One cycle: check, drive, then predict from the model
   task automatic apply_op(input logic do_lookup, input lookup_req_t lk,
                           input logic do_fill, input fill_req_t fl);
      lookup_rsp_t exp_rsp;
      @(negedge clka);
      check_outputs();
      lookup_d1 = do_lookup;
      lookup_valid = do_lookup;
      lookup = lk;
      fill_valid = do_fill;
      fill = fl;
      // Lookup sees the entry before a same-cycle fill
      if (do_lookup) begin
         exp_rsp.entry = model[lk.index];
         exp_rsp.hit = model[lk.index].valid && (model[lk.index].tag == lk.tag);
         exp_q.push_back(exp_rsp);
      end
      if (do_fill) begin
         model[fl.index] = fl.entry;
      end
   endtask

   task automatic run_row(input stim_row_t row);
      lookup_req_t lk;
      fill_req_t   fl;
      lk.index = row.index;
      lk.tag = row.tag;
      fl.index = row.index;
      fl.entry.valid = row.valid;
      fl.entry.tag = row.tag;
      apply_op(row.op[0], lk, row.op[1], fl);
   endtask

   // Small index and tag sets so that hits and same-index pairs occur
   task automatic run_random_op();
      logic [31:0] r;
      logic [1:0]  op;
      lookup_req_t lk;
      fill_req_t   fl;
      logic [1:0]  sub;
      logic        same;
      take_bits(2, r);
      op = r[1:0];
      take_bits(2, r);
      sub = r[1:0];
      take_bits(3, r);
      lk.index = {sub, 2'b01, r[2:0]};
      take_bits(2, r);
      lk.tag = {21'h0A5A5A, r[1:0]};
      take_bits(1, r);
      same = r[0];
      take_bits(2, r);
      sub = r[1:0];
      take_bits(3, r);
      fl.index = same ? lk.index : {sub, 2'b01, r[2:0]};
      take_bits(2, r);
      fl.entry.tag = {21'h0A5A5A, r[1:0]};
      // Three in four fills are valid
      take_bits(2, r);
      fl.entry.valid = |r[1:0];
      apply_op(op[0], lk, op[1], fl);
   endtask

   initial begin
      int drain;
      clka = 1'b0;
      rst_n = 1'b0;
      lookup_valid = 1'b0;
      lookup = '0;
      fill_valid = 1'b0;
      fill = '0;
      lookup_d1 = 1'b0;
      cycle_cnt = 0;
      lfsr_state = 16'd6701;
      for (int i = 0; i < 2**INDEX_W; i++) begin
         model[i] = '0;
      end

      repeat (RESET_CYCLES) @(negedge clka);
      rst_n = 1'b1;

      for (int i = 0; i < NUM_ROWS; i++) begin
         run_row(stim_table[i]);
      end
      for (int i = 0; i < RAND_OPS; i++) begin
         run_random_op();
      end

      // Idle until the last responses are in
      drain = 0;
      while (exp_q.size() != 0 && drain < DRAIN_LIMIT) begin
         apply_op(1'b0, '0, 1'b0, '0);
         drain++;
      end

      if (exp_q.size() == 0) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         $display("%0d lookups never got a response", exp_q.size());
         stop_run();
      end
   end

endmodule

// File: test/tag_store_props.sv
//--------------------------------------------------------------------------
// Concurrent checks on the tag store ports, bound into tag_store_top
// Timing checks are disabled while rst_n is low
// Failures are reported through the assertion action blocks only
//--------------------------------------------------------------------------
module tag_store_props
   import tag_pkg::*;
(
   input logic        clka,
   input logic        rst_n,
   input logic        lookup_valid,
   input logic        rsp_valid,
   input lookup_rsp_t rsp
);

   timeunit 1ns;
   timeprecision 1ps;

   // One response per lookup, exactly one cycle later
   rsp_follows_lookup: assert property (
      @(posedge clka) disable iff (!rst_n)
      rsp_valid == $past(lookup_valid)
   ) else $error("rsp_valid does not follow lookup_valid by one cycle");

   // No response while in reset
   quiet_in_reset: assert property (
      @(posedge clka) !rst_n |-> !rsp_valid
   ) else $error("rsp_valid high during reset");

   // A hit is only possible on a valid entry
   hit_needs_valid: assert property (
      @(posedge clka) disable iff (!rst_n)
      (rsp_valid && rsp.hit) |-> rsp.entry.valid
   ) else $error("hit reported on an invalid entry");

endmodule

// Attach to every instance of the top level
bind tag_store_top tag_store_props u_props (
   .clka         (clka),
   .rst_n        (rst_n),
   .lookup_valid (lookup_valid),
   .rsp_valid    (rsp_valid),
   .rsp          (rsp)
);

// File: src/tag_store_top.sv
//--------------------------------------------------------------------------
// Tag store of a direct-mapped cache, 128 entries of {valid, tag}
// Lookup at edge N gives rsp_valid and rsp after edge N+1
// Fill at edge N is visible to lookups sampled from edge N+1 on
// A lookup and a fill to the same index in one cycle return the old entry
// No handshake and no back-pressure; requests are one-cycle strobes
// Entries start invalid through zeroed RAM contents, not through rst_n
//--------------------------------------------------------------------------
module tag_store_top
   import tag_pkg::*;
(
   input  logic        clka,
   input  logic        rst_n,
   input  logic        lookup_valid,
   input  lookup_req_t lookup,
   input  logic        fill_valid,
   input  fill_req_t   fill,
   output logic        rsp_valid,
   output lookup_rsp_t rsp
);

   // Lookup request fields
   index_t lookup_index;
   tag_t   lookup_tag;

   // Entry read for the lookup in flight
   tag_entry_t rd_entry;

   assign lookup_index = lookup.index;
   assign lookup_tag   = lookup.tag;

   // Storage
   // Read port serves lookups, write port serves fills
   tag_bank u_tag_bank (
      .clka     (clka),
      .rst_n    (rst_n),
      .rd_en    (lookup_valid),
      .rd_index (lookup_index),
      .wr_en    (fill_valid),
      .wr       (fill),
      .rd_entry (rd_entry)
   );

   // Hit detection and response
   // Tag is delayed inside to line up with rd_entry
   tag_compare u_tag_compare (
      .clka         (clka),
      .rst_n        (rst_n),
      .lookup_valid (lookup_valid),
      .lookup_tag   (lookup_tag),
      .rd_entry     (rd_entry),
      .rsp_valid    (rsp_valid),
      .rsp          (rsp)
   );

endmodule

// File: src/tag_compare.sv
//--------------------------------------------------------------------------
// Hit logic of the tag store
// Aligns the lookup tag with the entry read one cycle later
// rsp_valid is a one-cycle pulse per lookup, never stalled
// A new lookup may be sampled while the previous result is presented
//--------------------------------------------------------------------------
module tag_compare
   import tag_pkg::*;
(
   input  logic        clka,
   input  logic        rst_n,
   input  logic        lookup_valid,
   input  tag_t        lookup_tag,
   input  tag_entry_t  rd_entry,
   output logic        rsp_valid,
   output lookup_rsp_t rsp
);

   // Lookup strobe delayed to match the RAM read
   logic lookup_valid_q;
   // Tag of the lookup in flight
   tag_t lookup_tag_q;
   // Stored tag matches the requested one
   logic tag_match;

   // Strobe pipeline
   // Cleared by reset so no response appears before the first lookup
   always_ff @(posedge clka or negedge rst_n) begin
      if (!rst_n) begin
         lookup_valid_q <= 1'b0;
      end else begin
         lookup_valid_q <= lookup_valid;
      end
   end

   // Tag pipeline
   // Loaded per lookup, so it holds along with rd_entry in idle cycles
   always_ff @(posedge clka) begin
      if (lookup_valid) begin
         lookup_tag_q <= lookup_tag;
      end
   end

   // Compare against the stored tag
   assign tag_match = (rd_entry.tag == lookup_tag_q);

   // Response pulse
   assign rsp_valid = lookup_valid_q;

   // Hit needs both a valid entry and a matching tag
   assign rsp.hit = rd_entry.valid & tag_match;

   // Stored entry goes out on hit and miss alike
   assign rsp.entry = rd_entry;

endmodule

// File: tag_bank/tag_bank.sv
//--------------------------------------------------------------------------
// Tag array built from four RAM subbanks
// Index top bits pick the subbank, low bits pick the row
// One read and one write per cycle, to any subbanks, even the same entry
// A read to the entry being written returns the old contents
// rd_entry is valid the cycle after rd_en and holds otherwise
//--------------------------------------------------------------------------
module tag_bank
   import tag_pkg::*;
(
   input  logic       clka,
   input  logic       rst_n,
   input  logic       rd_en,
   input  index_t     rd_index,
   input  logic       wr_en,
   input  fill_req_t  wr,
   output tag_entry_t rd_entry
);

   // Index fields of both ports
   subbank_sel_t rd_sub;
   subbank_sel_t wr_sub;
   row_t         rd_row;
   row_t         wr_row;

   // Per-subbank strobes
   logic [SUBBANK_CNT-1:0] sb_cs;
   logic [SUBBANK_CNT-1:0] sb_re;
   logic [SUBBANK_CNT-1:0] sb_we;

   // Read data of each subbank
   tag_entry_t sb_dout [SUBBANK_CNT];

   // Subbank of the read in flight
   subbank_sel_t rd_sub_q;

   // Split the indexes
   assign rd_sub = rd_index[INDEX_W-1 -: SUBBANK_SEL_W];
   assign rd_row = rd_index[ROW_W-1:0];
   assign wr_sub = wr.index[INDEX_W-1 -: SUBBANK_SEL_W];
   assign wr_row = wr.index[ROW_W-1:0];

   // One subbank per select value
   for (genvar g = 0; g < SUBBANK_CNT; g++) begin : g_subbank
      // Read aimed at this subbank
      assign sb_re[g] = rd_en & (rd_sub == subbank_sel_t'(g));
      // Write aimed at this subbank
      assign sb_we[g] = wr_en & (wr_sub == subbank_sel_t'(g));
      // Selected for either access
      assign sb_cs[g] = sb_re[g] | sb_we[g];

      bram_subbank #(
         .DEPTH      (SUBBANK_DEPTH),
         .DATA_WIDTH (ENTRY_W)
      ) u_subbank (
         .clka  (clka),
         .din   (wr.entry),
         .raddr (rd_row),
         .waddr (wr_row),
         .cs    (sb_cs[g]),
         .re    (sb_re[g]),
         .we    (sb_we[g]),
         .dout  (sb_dout[g])
      );
   end

   // Remember which subbank was read
   // Only updated on a read so the output holds between lookups
   always_ff @(posedge clka or negedge rst_n) begin
      if (!rst_n) begin
         rd_sub_q <= '0;
      end else if (rd_en) begin
         rd_sub_q <= rd_sub;
      end
   end

   // Output mux
   // Back-to-back reads to different subbanks each pick their own data
   assign rd_entry = sb_dout[rd_sub_q];

endmodule

// File: tag_bank/bram_subbank.sv
//--------------------------------------------------------------------------
// Single-clock RAM subbank, one read port and one write port
// Read data is registered and returns the contents before a same-edge write
// dout holds its last value while no read is enabled
// Contents start at zero; there is no reset of the array
//--------------------------------------------------------------------------
module bram_subbank #(
   parameter int DEPTH      = 32,
   parameter int DATA_WIDTH = 24
) (
   input  logic                     clka,
   input  logic [DATA_WIDTH-1:0]    din,
   input  logic [$clog2(DEPTH)-1:0] raddr,
   input  logic [$clog2(DEPTH)-1:0] waddr,
   input  logic                     cs,
   input  logic                     re,
   input  logic                     we,
   output logic [DATA_WIDTH-1:0]    dout
);

   // Storage, meant to map onto block RAM
   logic [DATA_WIDTH-1:0] mem [DEPTH];

   // Enables qualified by chip select
   logic ren;
   logic wen;

   assign ren = cs & re;
   assign wen = cs & we;

   // Write port
   always @(posedge clka) begin
      if (wen) begin
         mem[waddr] <= din;
      end
   end

   // Registered read, old data on a same-address write
   always_ff @(posedge clka) begin
      if (ren) begin
         dout <= mem[raddr];
      end
   end

   // Zero contents at start
   // Entries therefore read as invalid before any fill
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = '0;
      end
   end

endmodule

// File: common/tag_pkg.sv
//--------------------------------------------------------------------------
// Shared widths, vector types and request structs of the cache tag store
// Direct-mapped, 128 entries in four subbanks of 32 rows each
// An index is {subbank, row} with the subbank number in the top bits
// An entry is {valid, tag} with the valid bit in the MSB
// Zero contents mean invalid, so no reset of the entries is needed
//--------------------------------------------------------------------------
package tag_pkg;

   // Stored tag width
   localparam int TAG_W = 23;
   // Cache index width, covers all 128 entries
   localparam int INDEX_W = 7;

   // Subbank organisation
   localparam int SUBBANK_CNT   = 4;
   localparam int SUBBANK_SEL_W = 2;
   localparam int SUBBANK_DEPTH = 32;
   // Row address inside one subbank
   localparam int ROW_W = 5;

   // One valid bit plus the tag
   localparam int ENTRY_W = 24;

   // Plain vector types
   typedef logic [TAG_W-1:0]         tag_t;
   typedef logic [INDEX_W-1:0]       index_t;
   typedef logic [ROW_W-1:0]         row_t;
   typedef logic [SUBBANK_SEL_W-1:0] subbank_sel_t;

   // Stored entry, exactly ENTRY_W bits
   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   // Lookup request
   // Tag is compared one cycle later against the stored entry
   typedef struct packed {
      index_t index;
      tag_t   tag;
   } lookup_req_t;

   // Fill request
   // Entry with valid clear invalidates the index
   typedef struct packed {
      index_t     index;
      tag_entry_t entry;
   } fill_req_t;

   // Lookup response
   // Entry is returned on a miss as well
   typedef struct packed {
      logic       hit;
      tag_entry_t entry;
   } lookup_rsp_t;

endpackage
